//--- stack_cpu.f
+incdir+.
isa_pkg.sv
ctrl_pkg.sv
alu.sv
lifo_stack.sv
flag_cond.sv
program_counter.sv
control.sv
cpu.sv
cpu_tb.sv

//--- Makefile
# Verilator build and run for the stack_cpu core

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= stack_cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- cpu_stim.txt
# p <addr> <word> : program or data word, hex
# w <addr> <data> : expected memory write, hex, in order
# Register and immediate ALU operations
p 00 1100
p 01 2170
p 02 1200
p 03 5225
p 04 1300
p 05 53FD
p 06 1400
p 07 0422
p 08 0453
p 09 9401
p 0A 5101
p 0B 0443
p 0C 0433
p 0D 9401
p 0E 5101
p 0F 0413
p 10 0462
p 11 0472
p 12 9401
p 13 5101
p 14 340F
p 15 4417
p 16 6400
p 17 7400
p 18 2405
p 19 147E
p 1A 9401
p 1B 5101
# Markers and jump target setup
p 1C 1800
p 1D 285A
p 1E 1900
p 1F 2966
p 20 1500
p 21 2522
# Conditional jumps on zero, carry, parity, overflow, negative
p 22 5506
p 23 1600
p 24 A205
p 25 9801
p 26 A105
p 27 9901
p 28 5506
p 29 4601
p 2A A605
p 2B 9801
p 2C A505
p 2D 9901
p 2E 5506
p 2F 7600
p 30 AA05
p 31 9801
p 32 A905
p 33 9901
p 34 5506
p 35 5601
p 36 A805
p 37 9801
p 38 A705
p 39 9901
p 3A 5506
p 3B 2600
p 3C A405
p 3D 9801
p 3E A305
p 3F 9901
# Load and store at a computed address
p 40 1200
p 41 2260
p 42 6200
p 43 8402
p 44 5210
p 45 9402
# Parameter stack
p 46 420F
p 47 8F02
p 48 5201
p 49 8F02
p 4A 5201
p 4B 8F02
p 4C 0F5F
p 4D 9F01
p 4E 9F01
p 4F 9F01
# Call and return through R14
p 50 1300
p 51 2358
p 52 BE03
p 53 9401
p 54 F000
p 58 9601
p 59 A00E
# Data words
p C0 1234
p C1 0111
p C2 0222
p C3 0333
# Expected writes
w 70 0022
w 71 FFD8
w 72 7FD8
w 73 0044
w 74 005A
w 74 005A
w 74 005A
w 74 005A
w 74 005A
w D0 1234
w 74 0666
w 74 0222
w 74 0111
w 74 8000
w 74 1234

//--- cpu_tb.sv
`include "stack_cpu_cfg.svh"

module cpu_tb;

   localparam int MEM_WORDS   = 256;
   localparam int HALT_LIMIT  = 5000;  // Cycles allowed to reach halted
   localparam int HOLD_CYCLES = 6;

   logic        clk;
   logic        rst;
   logic        en;
   logic [15:0] mem_rd_data;
   logic [15:0] mem_addr;
   logic        mem_rd_en;
   logic        mem_wr_en;
   logic [15:0] mem_wr_data;
   logic        halted;

   logic [15:0] mem [MEM_WORDS];
   logic [15:0] exp_addr [$];
   logic [15:0] exp_data [$];
   int          errors;
   integer      seed;

   // Strobes captured at the falling edge
   logic        rd_en_s;
   logic        wr_en_s;
   logic [15:0] addr_s;
   logic [15:0] wr_data_s;

   cpu cpu_i (
      .clk         (clk),
      .rst         (rst),
      .en          (en),
      .mem_rd_data (mem_rd_data),
      .mem_addr    (mem_addr),
      .mem_rd_en   (mem_rd_en),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_data (mem_wr_data),
      .halted      (halted)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////
   // Memory model
   ////////////////////////////////////////

   always @(negedge clk) begin
      rd_en_s   = mem_rd_en;
      wr_en_s   = mem_wr_en;
      addr_s    = mem_addr;
      wr_data_s = mem_wr_data;
      if (rst && (mem_rd_en || mem_wr_en || halted)) begin
         $display("error: %0t strobes or halted active during reset", $time);
         errors++;
      end
      if (!rst && !en && (mem_rd_en || mem_wr_en)) begin
         $display("error: %0t memory strobe active while en is low", $time);
         errors++;
      end
   end

   always @(posedge clk) begin
      #10;
      if ((rd_en_s || wr_en_s) && addr_s >= MEM_WORDS) begin
         $display("error: %0t memory address %h out of range", $time, addr_s);
         errors++;
      end
      if (wr_en_s) begin
         check_write(addr_s, wr_data_s);
         mem[addr_s[7:0]] = wr_data_s;
      end
      if (rd_en_s) mem_rd_data = mem[addr_s[7:0]];  // One cycle read latency
   end

   task automatic check_write(input logic [15:0] addr, input logic [15:0] data);
      logic [15:0] want_addr;
      logic [15:0] want_data;
      if (exp_addr.size() == 0) begin
         $display("error: %0t unexpected write %h to %h", $time, data, addr);
         errors++;
      end else begin
         want_addr = exp_addr.pop_front();
         want_data = exp_data.pop_front();
         if (addr != want_addr || data != want_data) begin
            $display("error: %0t write %h to %h, expected %h to %h",
                     $time, data, addr, want_data, want_addr);
            errors++;
         end
      end
   endtask

   ////////////////////////////////////////
   // Stimulus file and enable pauses
   ////////////////////////////////////////

   task automatic load_stim();
      integer          fd;
      integer          n;
      logic [8*8-1:0]  tag;
      logic [8*128-1:0] line;
      logic [15:0]     a;
      logic [15:0]     d;
      bit              done;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = {8'hE5, i[7:0]};  // No-op opcode with the address in the low byte
      end
      done = 1'b0;
      fd   = $fopen("cpu_stim.txt", "r");
      if (fd == 0) begin
         $display("could not open the stimulus file cpu_stim.txt");
         errors++;
         done = 1'b1;
      end
      while (!done) begin
         n = $fscanf(fd, " %s", tag);
         if (n != 1) begin
            done = 1'b1;
         end else if (tag == "#") begin
            n = $fgets(line, fd);
         end else if (tag == "p") begin
            n = $fscanf(fd, " %h %h", a, d);
            mem[a[7:0]] = d;
         end else if (tag == "w") begin
            n = $fscanf(fd, " %h %h", a, d);
            exp_addr.push_back(a);
            exp_data.push_back(d);
         end else begin
            $display("stimulus file holds a line with an unknown tag");
            errors++;
            done = 1'b1;
         end
      end
      if (fd != 0) $fclose(fd);
   endtask

   task automatic drive_enable();
      int pause;
      pause = 0;
      forever begin
         @(posedge clk);
         #10;
         if (pause > 0) begin
            en = 1'b0;
            pause--;
         end else begin
            en = 1'b1;
            if ($random(seed) % 4 == 0) pause = $random(seed) & 3;  // 0 to 3 cycles
         end
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      int cycles;
      errors      = 0;
      seed        = 32'ha3ad_775c;
      rst         = 1'b1;
      en          = 1'b1;  // Held high through reset
      mem_rd_data = '0;
      load_stim();

      repeat (8) @(posedge clk);
      #10;
      rst = 1'b0;
      fork
         drive_enable();
      join_none

      cycles = 0;
      while (!halted && cycles < HALT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("timeout: core did not reach halted within %0d cycles", HALT_LIMIT);
         errors++;
      end else begin
         for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (!halted) begin
               $display("error: %0t core left the halted state", $time);
               errors++;
            end
         end
      end
      if (exp_addr.size() != 0) begin
         $display("%0d expected memory writes never happened", exp_addr.size());
         errors++;
      end

      $display("writes left %0d, errors %0d", exp_addr.size(), errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- cpu.sv
`include "stack_cpu_cfg.svh"

module cpu (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  en,
   input  logic [`SC_WORD_W-1:0] mem_rd_data,
   output logic [`SC_WORD_W-1:0] mem_addr,
   output logic                  mem_rd_en,
   output logic                  mem_wr_en,
   output logic [`SC_WORD_W-1:0] mem_wr_data,
   output logic                  halted
);

   localparam int W = `SC_WORD_W;

   logic [W-1:0]                  inst_reg;
   logic [W-1:0]                  a_reg;
   logic [W-1:0]                  b_reg;
   logic [W-1:0]                  result_q;
   logic [isa_pkg::NUM_FLAGS-1:0] flags_q;
   logic [W-1:0]                  regs [`SC_NUM_GREGS];

   logic [3:0] op_q, dest_q, ext_q, src_q;     // Latched instruction fields
   logic [3:0] dec_op, dec_ext, a_sel, b_sel;  // Fields seen by decode

   logic             inst_load, a_rd_en, b_rd_en, reg_wr_en;
   logic             set_flags, set_result, imm_to_b;
   logic             pc_to_reg, mem_to_reg, decode_from_mem, b_to_mem_addr;
   logic             cond_ok;
   ctrl_pkg::pc_op_t pc_op;
   logic [W-1:0]     pc;

   logic [W-1:0]                  alu_b, alu_result, wb_data;
   logic [isa_pkg::NUM_FLAGS-1:0] alu_flags;
   isa_pkg::alu_fn_t              alu_fn;
   logic [W-1:0]                  pstack_top, rstack_top;
   logic                          pstack_push, pstack_pop, rstack_push, rstack_pop;

   ////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////

   assign {op_q, dest_q, ext_q, src_q} = inst_reg;

   // Word is still on the bus during DECODE
   assign dec_op  = decode_from_mem ? mem_rd_data[15:12] : op_q;
   assign a_sel   = decode_from_mem ? mem_rd_data[11:8]  : dest_q;
   assign dec_ext = decode_from_mem ? mem_rd_data[7:4]   : ext_q;
   assign b_sel   = decode_from_mem ? mem_rd_data[3:0]   : src_q;

   assign mem_addr    = b_to_mem_addr ? b_reg : pc;
   assign mem_wr_data = a_reg;

   always_ff @(posedge clk) begin
      if (inst_load)  inst_reg <= mem_rd_data;
      if (set_result) result_q <= alu_result;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         flags_q <= '0;
      end else if (set_flags) begin
         flags_q <= alu_flags;
      end
   end

   ////////////////////////////////////////
   // Register file and stack mapping
   ////////////////////////////////////////

   function automatic logic [`SC_WORD_W-1:0] read_reg(input logic [3:0] sel);
      case (sel)
         `SC_PSTACK_REG: return pstack_top;
         `SC_RSTACK_REG: return rstack_top;
         default:        return regs[sel];
      endcase
   endfunction

   always_ff @(posedge clk) begin
      if (a_rd_en) a_reg <= read_reg(a_sel);
      if (b_rd_en) b_reg <= read_reg(b_sel);
      if (reg_wr_en && dest_q < `SC_NUM_GREGS) regs[dest_q] <= wb_data;
   end

   // Write-back source
   assign wb_data = mem_to_reg ? mem_rd_data : (pc_to_reg ? pc : result_q);

   // Same stack on both operands pops once
   assign pstack_push = reg_wr_en && (dest_q == `SC_PSTACK_REG);
   assign rstack_push = reg_wr_en && (dest_q == `SC_RSTACK_REG);
   assign pstack_pop  = (a_rd_en && a_sel == `SC_PSTACK_REG) ||
                        (b_rd_en && b_sel == `SC_PSTACK_REG);
   assign rstack_pop  = (a_rd_en && a_sel == `SC_RSTACK_REG) ||
                        (b_rd_en && b_sel == `SC_RSTACK_REG);

   lifo_stack param_stack (
      .clk       (clk),
      .rst       (rst),
      .push      (pstack_push),
      .pop       (pstack_pop),
      .push_data (wb_data),
      .pop_data  (pstack_top)
   );

   lifo_stack return_stack (
      .clk       (clk),
      .rst       (rst),
      .push      (rstack_push),
      .pop       (rstack_pop),
      .push_data (wb_data),
      .pop_data  (rstack_top)
   );

   ////////////////////////////////////////
   // Execute blocks
   ////////////////////////////////////////

   assign alu_b  = imm_to_b ? {{(W-8){ext_q[3]}}, ext_q, src_q} : b_reg;
   assign alu_fn = isa_pkg::alu_fn_t'((op_q == isa_pkg::OP_ALU) ? ext_q : op_q);

   alu alu_i (
      .a      (a_reg),
      .b      (alu_b),
      .fn     (alu_fn),
      .result (alu_result),
      .flags  (alu_flags)
   );

   flag_cond flag_cond_i (
      .cond    (isa_pkg::cond_t'(a_sel)),  // cond shares the dest field
      .flags   (flags_q),
      .cond_ok (cond_ok)
   );

   program_counter program_counter_i (
      .clk        (clk),
      .rst        (rst),
      .pc_op      (pc_op),
      .load_value (b_reg),
      .pc         (pc)
   );

   control control_i (
      .clk             (clk),
      .rst             (rst),
      .en              (en),
      .op              (isa_pkg::opcode_t'(dec_op)),
      .ext             (dec_ext),
      .cond_ok         (cond_ok),
      .mem_rd_en       (mem_rd_en),
      .mem_wr_en       (mem_wr_en),
      .inst_load       (inst_load),
      .a_rd_en         (a_rd_en),
      .b_rd_en         (b_rd_en),
      .reg_wr_en       (reg_wr_en),
      .set_flags       (set_flags),
      .set_result      (set_result),
      .imm_to_b        (imm_to_b),
      .pc_op           (pc_op),
      .pc_to_reg       (pc_to_reg),
      .mem_to_reg      (mem_to_reg),
      .decode_from_mem (decode_from_mem),
      .b_to_mem_addr   (b_to_mem_addr),
      .halted          (halted)
   );

endmodule

//--- control.sv
module control (
   input  logic              clk,
   input  logic              rst,
   input  logic              en,
   input  isa_pkg::opcode_t  op,
   input  logic [3:0]        ext,
   input  logic              cond_ok,
   output logic              mem_rd_en,
   output logic              mem_wr_en,
   output logic              inst_load,
   output logic              a_rd_en,
   output logic              b_rd_en,
   output logic              reg_wr_en,
   output logic              set_flags,
   output logic              set_result,
   output logic              imm_to_b,
   output ctrl_pkg::pc_op_t  pc_op,
   output logic              pc_to_reg,
   output logic              mem_to_reg,
   output logic              decode_from_mem,
   output logic              b_to_mem_addr,
   output logic              halted
);

   ctrl_pkg::state_t state;
   ctrl_pkg::state_t state_nxt;
   logic             go;          // No strobes while reset is high
   logic             is_reg_alu;
   logic             is_imm_alu;
   logic             is_alu;
   logic             is_mem;

   assign go         = en && !rst;
   assign is_reg_alu = (op == isa_pkg::OP_ALU) && (ext >= 4'd1) && (ext <= 4'd7);
   assign is_imm_alu = (op >= isa_pkg::OP_ANDI) && (op <= isa_pkg::OP_SHRI);
   assign is_alu     = is_reg_alu || is_imm_alu;
   assign is_mem     = (op == isa_pkg::OP_LOAD) || (op == isa_pkg::OP_STORE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ctrl_pkg::FETCH;
      end else if (go) begin
         state <= state_nxt;  // Frozen while en is low
      end
   end

   always_comb begin
      case (state)
         ctrl_pkg::FETCH:  state_nxt = ctrl_pkg::DECODE;
         ctrl_pkg::DECODE: state_nxt = (op == isa_pkg::OP_HALT) ? ctrl_pkg::HALTED
                                                                 : ctrl_pkg::EXEC;
         ctrl_pkg::EXEC: begin
            if (is_alu || op == isa_pkg::OP_LOAD || op == isa_pkg::OP_CALL) begin
               state_nxt = ctrl_pkg::WRITE;
            end else begin
               state_nxt = ctrl_pkg::FETCH;
            end
         end
         ctrl_pkg::WRITE:  state_nxt = ctrl_pkg::FETCH;
         default:          state_nxt = ctrl_pkg::HALTED;  // Only reset leaves
      endcase
   end

   ////////////////////////////////////////
   // Datapath selects and strobes
   ////////////////////////////////////////

   always_comb begin
      decode_from_mem = (state == ctrl_pkg::DECODE);
      b_to_mem_addr   = (state == ctrl_pkg::EXEC) && is_mem;
      imm_to_b        = is_imm_alu;
      mem_to_reg      = (op == isa_pkg::OP_LOAD);
      pc_to_reg       = (op == isa_pkg::OP_CALL);  // Return pc as write data
      halted          = (state == ctrl_pkg::HALTED);

      mem_rd_en  = 1'b0;
      mem_wr_en  = 1'b0;
      inst_load  = 1'b0;
      a_rd_en    = 1'b0;
      b_rd_en    = 1'b0;
      reg_wr_en  = 1'b0;
      set_flags  = 1'b0;
      set_result = 1'b0;
      pc_op      = ctrl_pkg::PC_HOLD;

      if (go) begin
         case (state)
            ctrl_pkg::FETCH: begin
               mem_rd_en = 1'b1;
               pc_op     = ctrl_pkg::PC_INC;
            end
            ctrl_pkg::DECODE: begin
               inst_load = 1'b1;
               a_rd_en   = is_alu || (op == isa_pkg::OP_STORE);
               // Untaken jumps leave the target register alone
               b_rd_en   = is_reg_alu || is_mem || (op == isa_pkg::OP_CALL) ||
                           ((op == isa_pkg::OP_JMP) && cond_ok);
            end
            ctrl_pkg::EXEC: begin
               set_result = is_alu;
               set_flags  = is_alu;
               mem_wr_en  = (op == isa_pkg::OP_STORE);
               mem_rd_en  = (op == isa_pkg::OP_LOAD);   // Data read at b
               if ((op == isa_pkg::OP_JMP) && cond_ok) pc_op = ctrl_pkg::PC_LOAD;
            end
            ctrl_pkg::WRITE: begin
               reg_wr_en = 1'b1;
               // Link and jump share one edge
               if (op == isa_pkg::OP_CALL) pc_op = ctrl_pkg::PC_LOAD;
            end
            default: pc_op = ctrl_pkg::PC_HOLD;
         endcase
      end
   end

endmodule

//--- program_counter.sv
`include "stack_cpu_cfg.svh"

module program_counter (
   input  logic                  clk,
   input  logic                  rst,
   input  ctrl_pkg::pc_op_t      pc_op,
   input  logic [`SC_WORD_W-1:0] load_value,
   output logic [`SC_WORD_W-1:0] pc
);

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else begin
         case (pc_op)
            ctrl_pkg::PC_INC:  pc <= pc + 1'b1;
            ctrl_pkg::PC_LOAD: pc <= load_value;  // Jump target
            default:           pc <= pc;
         endcase
      end
   end

endmodule

//--- flag_cond.sv
module flag_cond (
   input  isa_pkg::cond_t                cond,
   input  logic [isa_pkg::NUM_FLAGS-1:0] flags,
   output logic                          cond_ok
);

   always_comb begin
      case (cond)
         isa_pkg::COND_ALWAYS: cond_ok = 1'b1;
         isa_pkg::COND_Z:      cond_ok = flags[isa_pkg::FLAG_Z];
         isa_pkg::COND_NZ:     cond_ok = !flags[isa_pkg::FLAG_Z];
         isa_pkg::COND_N:      cond_ok = flags[isa_pkg::FLAG_N];
         isa_pkg::COND_NN:     cond_ok = !flags[isa_pkg::FLAG_N];
         isa_pkg::COND_C:      cond_ok = flags[isa_pkg::FLAG_C];
         isa_pkg::COND_NC:     cond_ok = !flags[isa_pkg::FLAG_C];
         isa_pkg::COND_V:      cond_ok = flags[isa_pkg::FLAG_V];
         isa_pkg::COND_NV:     cond_ok = !flags[isa_pkg::FLAG_V];
         isa_pkg::COND_PO:     cond_ok = flags[isa_pkg::FLAG_P];
         isa_pkg::COND_PE:     cond_ok = !flags[isa_pkg::FLAG_P];
         default:              cond_ok = 1'b0;  // Reserved codes never jump
      endcase
   end

endmodule

//--- lifo_stack.sv
`include "stack_cpu_cfg.svh"

module lifo_stack (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  push,
   input  logic                  pop,
   input  logic [`SC_WORD_W-1:0] push_data,
   output logic [`SC_WORD_W-1:0] pop_data
);

   localparam int PTR_W = $clog2(`SC_STACK_DEPTH);

   logic [`SC_WORD_W-1:0] entries [`SC_STACK_DEPTH];
   logic [PTR_W-1:0]      top;     // Index of the top entry
   logic [PTR_W-1:0]      top_up;

   assign top_up   = top + 1'b1;   // Wraps past the last entry
   assign pop_data = entries[top];

   always_ff @(posedge clk) begin
      if (rst) begin
         top <= '0;
      end else if (push && !pop) begin
         top <= top_up;
      end else if (pop && !push) begin
         top <= top - 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (push && pop) begin
         entries[top] <= push_data;     // Replace top in place
      end else if (push) begin
         entries[top_up] <= push_data;
      end
   end

endmodule

//--- alu.sv
`include "stack_cpu_cfg.svh"

module alu (
   input  logic [`SC_WORD_W-1:0]         a,
   input  logic [`SC_WORD_W-1:0]         b,
   input  isa_pkg::alu_fn_t              fn,
   output logic [`SC_WORD_W-1:0]         result,
   output logic [isa_pkg::NUM_FLAGS-1:0] flags
);

   localparam int W = `SC_WORD_W;

   logic [W:0] sum;   // Carry out in top bit
   logic [W:0] diff;  // Borrow in top bit
   logic       carry;
   logic       ovf;

   assign sum  = {1'b0, a} + {1'b0, b};
   assign diff = {1'b0, a} - {1'b0, b};

   always_comb begin
      result = b;  // Unlisted codes pass b through
      carry  = 1'b0;
      ovf    = 1'b0;
      case (fn)
         isa_pkg::ALU_AND: result = a & b;
         isa_pkg::ALU_OR:  result = a | b;
         isa_pkg::ALU_XOR: result = a ^ b;
         isa_pkg::ALU_SUB: begin
            result = diff[W-1:0];
            carry  = diff[W];
            ovf    = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
         end
         isa_pkg::ALU_ADD: begin
            result = sum[W-1:0];
            carry  = sum[W];
            ovf    = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
         end
         // Shifts use a only, by one place
         isa_pkg::ALU_SHL: begin
            result = {a[W-2:0], 1'b0};
            carry  = a[W-1];
         end
         isa_pkg::ALU_SHR: begin
            result = {1'b0, a[W-1:1]};
            carry  = a[0];
         end
         default: result = b;
      endcase
   end

   always_comb begin
      flags                  = '0;
      flags[isa_pkg::FLAG_Z] = (result == '0);
      flags[isa_pkg::FLAG_N] = result[W-1];
      flags[isa_pkg::FLAG_C] = carry;
      flags[isa_pkg::FLAG_V] = ovf;
      flags[isa_pkg::FLAG_P] = ^result;  // Odd count of ones
   end

endmodule

//--- ctrl_pkg.sv
package ctrl_pkg;

   ////////////////////////////////////////
   // Sequencer states
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      FETCH,   // Read word at pc
      DECODE,  // Latch instruction, read operands
      EXEC,
      WRITE,   // Register or stack write-back
      HALTED
   } state_t;

   ////////////////////////////////////////
   // Program counter update
   ////////////////////////////////////////

   typedef enum logic [1:0] {
      PC_HOLD = 2'd0,
      PC_INC  = 2'd1,
      PC_LOAD = 2'd2
   } pc_op_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

   // Top nibble of the instruction word
   typedef enum logic [3:0] {
      OP_ALU   = 4'h0,  // Register ALU op with ext as the function
      OP_ANDI  = 4'h1,
      OP_ORI   = 4'h2,
      OP_XORI  = 4'h3,
      OP_SUBI  = 4'h4,
      OP_ADDI  = 4'h5,
      OP_SHLI  = 4'h6,
      OP_SHRI  = 4'h7,
      OP_LOAD  = 4'h8,
      OP_STORE = 4'h9,
      OP_JMP   = 4'hA,
      OP_CALL  = 4'hB,
      OP_HALT  = 4'hF
   } opcode_t;

   typedef enum logic [3:0] {
      ALU_AND = 4'h1,
      ALU_OR  = 4'h2,
      ALU_XOR = 4'h3,
      ALU_SUB = 4'h4,
      ALU_ADD = 4'h5,
      ALU_SHL = 4'h6,
      ALU_SHR = 4'h7
   } alu_fn_t;

   // Jump condition codes above A never hold
   typedef enum logic [3:0] {
      COND_ALWAYS = 4'h0,
      COND_Z      = 4'h1,
      COND_NZ     = 4'h2,
      COND_N      = 4'h3,
      COND_NN     = 4'h4,
      COND_C      = 4'h5,
      COND_NC     = 4'h6,
      COND_V      = 4'h7,
      COND_NV     = 4'h8,
      COND_PO     = 4'h9,
      COND_PE     = 4'hA
   } cond_t;

   // Bit positions in the flag word
   localparam int FLAG_Z    = 0;
   localparam int FLAG_N    = 1;
   localparam int FLAG_C    = 2;
   localparam int FLAG_V    = 3;
   localparam int FLAG_P    = 4;
   localparam int NUM_FLAGS = 5;

endpackage

//--- stack_cpu_cfg.svh
`ifndef STACK_CPU_CFG_SVH
`define STACK_CPU_CFG_SVH

////////////////////////////////////////
// Core sizing
////////////////////////////////////////

`define SC_WORD_W      16   // Data and address width
`define SC_NUM_GREGS   14   // R0 to R13
`define SC_STACK_DEPTH 16   // Entries per stack

////////////////////////////////////////
// Register numbers mapped onto the stacks
////////////////////////////////////////

`define SC_RSTACK_REG  4'hE
`define SC_PSTACK_REG  4'hF

`endif
